/* include/gpio_settings.svh */
/*
  widths, register offsets and reset values shared by the gpio block.
  included by the package, the rtl and the testbench
*/
`ifndef GPIO_SETTINGS_SVH
`define GPIO_SETTINGS_SVH

// ---------------------------------------------------------------------------
// sizes
// ---------------------------------------------------------------------------
`define GPIO_WIDTH      16        // pins per bank
`define GPIO_ADDR_WIDTH 8         // bus address width

// ---------------------------------------------------------------------------
// bank-local offsets, decoded from addr[5:0]
// ---------------------------------------------------------------------------
`define GPR_DIRECTION_MODE 6'h04  // set bit puts pin in input mode
`define GPR_OUTPUT_ENABLE  6'h08  // drive enable per pin
`define GPR_OUTPUT_VALUE   6'h0C  // value driven onto the pad
`define GPR_INPUT_VALUE    6'h10  // synchronized pin state, read only
`define GPR_INT_STATUS     6'h20  // rising edge status, cleared on read

// merger registers, full 8-bit addresses
`define GPR_IRQ_MASK       8'h80  // bit per bank, 1 lets it reach irq
`define GPR_IRQ_PENDING    8'h84  // or of each bank's status, read only

// ---------------------------------------------------------------------------
// reset values
// ---------------------------------------------------------------------------
`define GPRV_DIRECTION_MODE 16'h0000  // all pins start as outputs
`define GPRV_OUTPUT_ENABLE  16'h0000  // no pad driven out of reset
`define GPRV_OUTPUT_VALUE   16'h0000  // driven low once enabled

`endif

/* logic/gpio_pkg.sv */
/*
  common types of the gpio block. widths come from the settings header,
  modules use the types by scoped name in ports and by import in the body
*/
`default_nettype none

`include "gpio_settings.svh"

package gpio_pkg;

  // one bank wide register, data word or pin vector
  typedef logic [`GPIO_WIDTH-1:0] gpio_word_t;

  // bus address as seen by banks and merger
  typedef logic [`GPIO_ADDR_WIDTH-1:0] gpio_addr_t;

  // both banks side by side at the top ports
  // bank 0 sits in the low half
  typedef logic [2*`GPIO_WIDTH-1:0] gpio_pins_t;

  // bank field of the address, addr[7:6]
  typedef logic [1:0] gpio_bank_sel_t;

endpackage : gpio_pkg

`default_nettype wire

/* logic/gpio_pin_bank.sv */
/*
  one bank of gpio pins. register file, two-flop input synchronizer,
  rising edge status gated by input mode, read-clear status and pad controls.
  instantiate once per bank with BANK_ID set to its addr[7:6] value
*/
`timescale 1ns/10ps
`default_nettype none

`include "gpio_settings.svh"

module gpio_pin_bank #(
  parameter gpio_pkg::gpio_bank_sel_t BANK_ID = 2'd0  // bank field this bank answers
) (
  input  wire                  pclk26,
  input  wire                  n_reset26,         // async, active low
  input  wire                  read,              // single cycle read strobe
  input  wire                  write,             // single cycle write strobe
  input  wire gpio_pkg::gpio_addr_t addr,
  input  wire gpio_pkg::gpio_word_t wdata,
  input  wire gpio_pkg::gpio_word_t pin_in,       // raw pad inputs, async
  input  wire gpio_pkg::gpio_word_t tri_state_enable,  // forces pads to z
  output gpio_pkg::gpio_word_t bank_rdata,        // registered, zero when idle
  output gpio_pkg::gpio_word_t interrupt,
  output gpio_pkg::gpio_word_t pin_out,
  output gpio_pkg::gpio_word_t pin_oe_n           // low drives the pad
);

  import gpio_pkg::*;

  // ---------------------------------------------------------------------------
  // address decode
  // ---------------------------------------------------------------------------
  logic       bank_hit;                           // addr[7:6] is ours
  logic [5:0] offset;                             // register inside the bank
  logic       status_clear;                       // read of int_status

  // programmable registers
  gpio_word_t direction_mode;                     // 1 input, 0 output
  gpio_word_t output_enable;
  gpio_word_t output_value;

  // input path
  gpio_word_t sync_one;                           // first stage, at the pad
  gpio_word_t sync_two;                           // second stage
  gpio_word_t input_value;                        // software visible
  gpio_word_t input_prev;                         // input_value a cycle ago
  gpio_word_t int_trigger;                        // set bits of int_status
  gpio_word_t int_status;

  assign bank_hit     = (gpio_bank_sel_t'(addr[`GPIO_ADDR_WIDTH-1 -: 2]) == BANK_ID);
  assign offset       = addr[`GPIO_ADDR_WIDTH-3:0];
  assign status_clear = read && bank_hit && (offset == `GPR_INT_STATUS);

  // ---------------------------------------------------------------------------
  // register writes, same edge as the strobe
  // ---------------------------------------------------------------------------
  always_ff @(posedge pclk26 or negedge n_reset26)
  begin
    if (!n_reset26)
    begin
      direction_mode <= `GPRV_DIRECTION_MODE;
      output_enable  <= `GPRV_OUTPUT_ENABLE;
      output_value   <= `GPRV_OUTPUT_VALUE;
    end
    else if (write && bank_hit)
    begin
      if (offset == `GPR_DIRECTION_MODE)
        direction_mode <= wdata;
      if (offset == `GPR_OUTPUT_ENABLE)
        output_enable <= wdata;
      if (offset == `GPR_OUTPUT_VALUE)
        output_value <= wdata;
      // input_value and int_status ignore writes
    end
  end

  // ---------------------------------------------------------------------------
  // input synchronizer, pin change visible in input_value after 3 edges
  // ---------------------------------------------------------------------------
  always_ff @(posedge pclk26 or negedge n_reset26)
  begin
    if (!n_reset26)
    begin
      sync_one    <= '0;
      sync_two    <= '0;
      input_value <= '0;
      input_prev  <= '0;
    end
    else
    begin
      sync_one    <= pin_in;
      sync_two    <= sync_one;
      input_value <= sync_two;
      input_prev  <= input_value;                 // edge reference
    end
  end

  // rising edge on a pin that is in input mode
  assign int_trigger = direction_mode & input_value & ~input_prev;

  // status bits, sticky until a read of INT_STATUS
  // a trigger in the clearing cycle survives the clear
  always_ff @(posedge pclk26 or negedge n_reset26)
  begin
    if (!n_reset26)
      int_status <= '0;
    else
      int_status <= (int_status & ~{`GPIO_WIDTH{status_clear}}) | int_trigger;
  end

  assign interrupt = int_status;

  // ---------------------------------------------------------------------------
  // read port, data one cycle after the strobe
  // ---------------------------------------------------------------------------
  always_ff @(posedge pclk26 or negedge n_reset26)
  begin
    if (!n_reset26)
      bank_rdata <= '0;
    else if (read && bank_hit)
    begin
      case (offset)
        `GPR_DIRECTION_MODE: bank_rdata <= direction_mode;
        `GPR_OUTPUT_ENABLE:  bank_rdata <= output_enable;
        `GPR_OUTPUT_VALUE:   bank_rdata <= output_value;
        `GPR_INT_STATUS:     bank_rdata <= int_status;
        default:             bank_rdata <= input_value;  // INPUT_VALUE and holes
      endcase
    end
    else
      bank_rdata <= '0;                           // other bank or no read
  end

  // pad controls, purely combinational
  assign pin_out  = output_value;
  assign pin_oe_n = ~(output_enable & ~direction_mode) | tri_state_enable;

endmodule : gpio_pin_bank

`default_nettype wire

/* logic/gpio_irq_merge.sv */
/*
  interrupt merger for the two gpio banks. holds the per-bank irq mask,
  shows the pending view, ors all read data onto rdata, drives the
  registered summary irq
*/
`timescale 1ns/10ps
`default_nettype none

`include "gpio_settings.svh"

module gpio_irq_merge (
  input  wire                  pclk26,
  input  wire                  n_reset26,
  input  wire                  read,
  input  wire                  write,
  input  wire gpio_pkg::gpio_addr_t addr,
  input  wire gpio_pkg::gpio_word_t wdata,
  input  wire gpio_pkg::gpio_word_t bank0_rdata,  // already registered
  input  wire gpio_pkg::gpio_word_t bank1_rdata,
  input  wire gpio_pkg::gpio_word_t bank0_int,
  input  wire gpio_pkg::gpio_word_t bank1_int,
  output gpio_pkg::gpio_word_t rdata,
  output logic                 irq               // one cycle behind pending & mask
);

  import gpio_pkg::*;

  logic [1:0] irq_mask;                           // bit n enables bank n
  logic [1:0] pending;                            // any status bit per bank
  gpio_word_t merge_rdata;                        // own read data

  assign pending = {|bank1_int, |bank0_int};

  // ---------------------------------------------------------------------------
  // mask register
  // ---------------------------------------------------------------------------
  always_ff @(posedge pclk26 or negedge n_reset26)
  begin
    if (!n_reset26)
      irq_mask <= 2'b00;
    else if (write && (addr == `GPR_IRQ_MASK))
      irq_mask <= wdata[1:0];                     // upper bits ignored
  end

  // own read port, same timing as the banks
  always_ff @(posedge pclk26 or negedge n_reset26)
  begin
    if (!n_reset26)
      merge_rdata <= '0;
    else if (read && (addr == `GPR_IRQ_MASK))
      merge_rdata <= {{(`GPIO_WIDTH-2){1'b0}}, irq_mask};
    else if (read && (addr == `GPR_IRQ_PENDING))
      merge_rdata <= {{(`GPIO_WIDTH-2){1'b0}}, pending};
    else
      merge_rdata <= '0;                          // zero keeps the or bus clean
  end

  // only the addressed source is nonzero, so a plain or is the mux
  assign rdata = merge_rdata | bank0_rdata | bank1_rdata;

  // ---------------------------------------------------------------------------
  // summary interrupt
  // ---------------------------------------------------------------------------
  always_ff @(posedge pclk26 or negedge n_reset26)
  begin
    if (!n_reset26)
      irq <= 1'b0;
    else
      irq <= |(pending & irq_mask);
  end

endmodule : gpio_irq_merge

`default_nettype wire

/* logic/gpio_lite_top.sv */
/*
  gpio top level. two 16-pin banks on one bus plus the interrupt merger,
  pin buses split with bank 0 in the low half
*/
`timescale 1ns/10ps
`default_nettype none

`include "gpio_settings.svh"

module gpio_lite_top (
  input  wire                  pclk26,
  input  wire                  n_reset26,
  input  wire                  read,
  input  wire                  write,
  input  wire gpio_pkg::gpio_addr_t addr,
  input  wire gpio_pkg::gpio_word_t wdata,
  input  wire gpio_pkg::gpio_pins_t pin_in,
  input  wire gpio_pkg::gpio_pins_t tri_state_enable,
  output wire gpio_pkg::gpio_word_t rdata,
  output wire gpio_pkg::gpio_pins_t interrupt,
  output wire gpio_pkg::gpio_pins_t pin_out,
  output wire gpio_pkg::gpio_pins_t pin_oe_n,
  output wire                  irq
);

  import gpio_pkg::*;

  gpio_word_t bank0_rdata;
  gpio_word_t bank1_rdata;
  gpio_word_t bank0_int;                          // status of bank 0
  gpio_word_t bank1_int;

  assign interrupt = {bank1_int, bank0_int};

  // low half
  gpio_pin_bank #(.BANK_ID(2'd0)) u_bank0 (
    .pclk26           (pclk26),
    .n_reset26        (n_reset26),
    .read             (read),
    .write            (write),
    .addr             (addr),
    .wdata            (wdata),
    .pin_in           (pin_in[`GPIO_WIDTH-1:0]),
    .tri_state_enable (tri_state_enable[`GPIO_WIDTH-1:0]),
    .bank_rdata       (bank0_rdata),
    .interrupt        (bank0_int),
    .pin_out          (pin_out[`GPIO_WIDTH-1:0]),
    .pin_oe_n         (pin_oe_n[`GPIO_WIDTH-1:0])
  );

  // high half
  gpio_pin_bank #(.BANK_ID(2'd1)) u_bank1 (
    .pclk26           (pclk26),
    .n_reset26        (n_reset26),
    .read             (read),
    .write            (write),
    .addr             (addr),
    .wdata            (wdata),
    .pin_in           (pin_in[2*`GPIO_WIDTH-1:`GPIO_WIDTH]),
    .tri_state_enable (tri_state_enable[2*`GPIO_WIDTH-1:`GPIO_WIDTH]),
    .bank_rdata       (bank1_rdata),
    .interrupt        (bank1_int),
    .pin_out          (pin_out[2*`GPIO_WIDTH-1:`GPIO_WIDTH]),
    .pin_oe_n         (pin_oe_n[2*`GPIO_WIDTH-1:`GPIO_WIDTH])
  );

  gpio_irq_merge u_merge (
    .pclk26      (pclk26),
    .n_reset26   (n_reset26),
    .read        (read),
    .write       (write),
    .addr        (addr),
    .wdata       (wdata),
    .bank0_rdata (bank0_rdata),
    .bank1_rdata (bank1_rdata),
    .bank0_int   (bank0_int),
    .bank1_int   (bank1_int),
    .rdata       (rdata),                         // or of all three read ports
    .irq         (irq)
  );

endmodule : gpio_lite_top

`default_nettype wire

/* testbench/gpio_props.sv */
/*
  concurrent checks on the gpio top level, bound into gpio_lite_top.
  covers idle read data, irq cause and the tri-state override
*/
`timescale 1ns/10ps
`default_nettype none

module gpio_props (
  input wire                       pclk26,
  input wire                       n_reset26,
  input wire                       read,
  input wire gpio_pkg::gpio_word_t rdata,
  input wire gpio_pkg::gpio_pins_t interrupt,
  input wire gpio_pkg::gpio_pins_t tri_state_enable,
  input wire gpio_pkg::gpio_pins_t pin_oe_n,
  input wire                       irq
);

  // ---------------------------------------------------------------------------
  // read bus
  // ---------------------------------------------------------------------------
  // no read strobe, nothing on the bus next cycle
  idle_read_zero: assert property (@(posedge pclk26) disable iff (!n_reset26)
    !read |=> (rdata == '0))
    else $error("rdata nonzero one cycle after a cycle without read");

  // summary irq needs a status bit one cycle earlier
  irq_has_cause: assert property (@(posedge pclk26) disable iff (!n_reset26)
    $rose(irq) |-> $past(|interrupt))
    else $error("irq rose with no interrupt bit set the cycle before");

  // override wins over enable and direction
  tri_state_wins: assert property (@(posedge pclk26) disable iff (!n_reset26)
    ((pin_oe_n & tri_state_enable) == tri_state_enable))
    else $error("pad driven while its tri-state override is high");

endmodule : gpio_props

bind gpio_lite_top gpio_props u_props (
  .pclk26           (pclk26),
  .n_reset26        (n_reset26),
  .read             (read),
  .rdata            (rdata),
  .interrupt        (interrupt),
  .tri_state_enable (tri_state_enable),
  .pin_oe_n         (pin_oe_n),
  .irq              (irq)
);

`default_nettype wire

/* testbench/gpio_clock_gen.sv */
/*
  clock and reset source for the gpio testbench.
  pclk26 runs at 10 ns, n_reset26 held low for the first 16 cycles
*/
`timescale 1ns/10ps
`default_nettype none

module gpio_clock_gen #(
  parameter int RESET_CYCLES = 16                 // cycles in reset
) (
  output logic pclk26,
  output logic n_reset26
);

  initial
  begin
    pclk26 = 1'b0;
    forever #5 pclk26 = ~pclk26;                  // 100 MHz
  end

  initial
  begin
    n_reset26 = 1'b0;
    repeat (RESET_CYCLES) @(posedge pclk26);
    n_reset26 <= 1'b1;                            // release on a rising edge
  end

endmodule : gpio_clock_gen

`default_nettype wire

/* testbench/gpio_tb.sv */
/*
  directed testbench for the two-bank gpio block. each test is a task
  driving the bus and pins on the rising edge and checking at the falling edge
*/
`timescale 1ns/10ps
`default_nettype none

`include "gpio_settings.svh"

module gpio_tb;

  import gpio_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;           // tests run about 400

  logic       pclk26;
  logic       n_reset26;
  logic       read;
  logic       write;
  gpio_addr_t addr;
  gpio_word_t wdata;
  gpio_pins_t pin_in;
  gpio_pins_t tri_state_enable;
  gpio_word_t rdata;
  gpio_pins_t interrupt;
  gpio_pins_t pin_out;
  gpio_pins_t pin_oe_n;
  logic       irq;

  gpio_word_t dir_q [2];                          // expected register contents
  gpio_word_t oe_q  [2];
  gpio_word_t out_q [2];
  int         cycle_count = 0;

  gpio_clock_gen clk_gen (
    .pclk26    (pclk26),
    .n_reset26 (n_reset26)
  );

  gpio_lite_top dut (
    .pclk26           (pclk26),
    .n_reset26        (n_reset26),
    .read             (read),
    .write            (write),
    .addr             (addr),
    .wdata            (wdata),
    .pin_in           (pin_in),
    .tri_state_enable (tri_state_enable),
    .rdata            (rdata),
    .interrupt        (interrupt),
    .pin_out          (pin_out),
    .pin_oe_n         (pin_oe_n),
    .irq              (irq)
  );

  // watchdog
  always @(posedge pclk26)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, tests did not complete", cycle_count);
      $display("Simulation failed");
      $fatal(1, "run stopped by watchdog");
    end
  end

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------
  task automatic check_word(input string name, input gpio_word_t got, input gpio_word_t exp);
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_pins(input string name, input gpio_pins_t got, input gpio_pins_t exp);
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic gpio_word_t rand_word();
    logic [31:0] r;
    r = $urandom;
    return r[`GPIO_WIDTH-1:0];
  endfunction

  // only banks 0 and 1 exist in the addr[7:6] field
  function automatic gpio_addr_t bank_addr(input logic bank, input logic [5:0] off);
    return {1'b0, bank, off};
  endfunction

  task automatic bus_write(input gpio_addr_t a, input gpio_word_t d);
    @(posedge pclk26);
    write <= 1'b1;
    addr  <= a;
    wdata <= d;
    @(posedge pclk26);                            // register takes it here
    write <= 1'b0;
  endtask

  // data sampled mid cycle one cycle after the strobe
  task automatic bus_read(input gpio_addr_t a, output gpio_word_t d);
    @(posedge pclk26);
    read <= 1'b1;
    addr <= a;
    @(posedge pclk26);
    read <= 1'b0;
    @(negedge pclk26);
    d = rdata;
  endtask

  task automatic write_bank_regs(input int i);
    bus_write(bank_addr(i[0], `GPR_DIRECTION_MODE), dir_q[i]);
    bus_write(bank_addr(i[0], `GPR_OUTPUT_ENABLE), oe_q[i]);
    bus_write(bank_addr(i[0], `GPR_OUTPUT_VALUE), out_q[i]);
  endtask

  task automatic clear_status();
    gpio_word_t dummy;
    bus_read(bank_addr(1'b0, `GPR_INT_STATUS), dummy);
    bus_read(bank_addr(1'b1, `GPR_INT_STATUS), dummy);
  endtask

  // ---------------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------------
  task automatic test_register_round_trip();
    gpio_word_t data;
    @(posedge pclk26);
    pin_in <= $urandom;                           // feeds the hole read
    for (int i = 0; i < 2; i++)
    begin
      dir_q[i] = rand_word();
      oe_q[i]  = rand_word();
      out_q[i] = rand_word();
      write_bank_regs(i);
    end
    for (int i = 0; i < 2; i++)
    begin
      bus_read(bank_addr(i[0], `GPR_DIRECTION_MODE), data);
      check_word("rdata direction_mode", data, dir_q[i]);
      @(negedge pclk26);
      check_word("rdata idle", rdata, '0);
      bus_read(bank_addr(i[0], `GPR_OUTPUT_ENABLE), data);
      check_word("rdata output_enable", data, oe_q[i]);
      bus_read(bank_addr(i[0], `GPR_OUTPUT_VALUE), data);
      check_word("rdata output_value", data, out_q[i]);
      bus_read(bank_addr(i[0], 6'h14), data);     // unmapped offset
      check_word("rdata unmapped", data, pin_in[i*`GPIO_WIDTH +: `GPIO_WIDTH]);
    end
  endtask

  task automatic test_pad_control();
    gpio_pins_t tri_pat;
    gpio_pins_t oe_all;
    gpio_pins_t dir_all;
    gpio_pins_t exp_oe_n;
    repeat (3)
    begin
      for (int i = 0; i < 2; i++)
      begin
        dir_q[i] = rand_word();
        oe_q[i]  = rand_word();
        out_q[i] = rand_word();
        write_bank_regs(i);
      end
      tri_pat = $urandom;
      @(posedge pclk26);
      tri_state_enable <= tri_pat;
      @(negedge pclk26);
      oe_all  = {oe_q[1], oe_q[0]};
      dir_all = {dir_q[1], dir_q[0]};
      exp_oe_n = '1;
      for (int b = 0; b < 2*`GPIO_WIDTH; b++)
        if (oe_all[b] && !dir_all[b] && !tri_pat[b])
          exp_oe_n[b] = 1'b0;                     // driven pad
      check_pins("pin_out", pin_out, {out_q[1], out_q[0]});
      check_pins("pin_oe_n", pin_oe_n, exp_oe_n);
    end
    @(posedge pclk26);
    tri_state_enable <= '0;
  endtask

  task automatic test_input_sync();
    gpio_word_t data;
    gpio_pins_t pattern;
    for (int i = 0; i < 2; i++)
    begin
      dir_q[i] = 16'hFFFF;                        // all inputs
      bus_write(bank_addr(i[0], `GPR_DIRECTION_MODE), dir_q[i]);
    end
    pattern = $urandom;
    @(posedge pclk26);
    pin_in <= pattern;
    repeat (3) @(posedge pclk26);                 // synchronizer latency
    for (int i = 0; i < 2; i++)
    begin
      bus_read(bank_addr(i[0], `GPR_INPUT_VALUE), data);
      check_word("rdata input_value", data, pattern[i*`GPIO_WIDTH +: `GPIO_WIDTH]);
    end
  endtask

  task automatic test_edge_interrupt();
    gpio_word_t data;
    gpio_pins_t rise;
    gpio_pins_t expected;
    for (int i = 0; i < 2; i++)
    begin
      dir_q[i] = rand_word();                     // mixed input and output pins
      bus_write(bank_addr(i[0], `GPR_DIRECTION_MODE), dir_q[i]);
    end
    @(posedge pclk26);
    pin_in <= '0;
    repeat (5) @(posedge pclk26);
    clear_status();
    @(negedge pclk26);
    check_pins("interrupt", interrupt, '0);
    rise = $urandom;
    expected = rise & {dir_q[1], dir_q[0]};       // only input-mode pins count
    @(posedge pclk26);
    pin_in <= rise;
    repeat (5) @(posedge pclk26);
    @(negedge pclk26);
    check_pins("interrupt", interrupt, expected);
    for (int i = 0; i < 2; i++)
    begin
      bus_read(bank_addr(i[0], `GPR_INT_STATUS), data);
      check_word("rdata int_status", data, expected[i*`GPIO_WIDTH +: `GPIO_WIDTH]);
      bus_read(bank_addr(i[0], `GPR_INT_STATUS), data);
      check_word("rdata int_status after clear", data, '0);
    end
    // falling edges leave status alone
    @(posedge pclk26);
    pin_in <= '0;
    repeat (5) @(posedge pclk26);
    @(negedge pclk26);
    check_pins("interrupt", interrupt, '0);
  endtask

  task automatic test_irq_merge();
    gpio_word_t data;
    bus_write(`GPR_IRQ_MASK, 16'h0002);           // bank 1 only
    bus_read(`GPR_IRQ_MASK, data);
    check_word("rdata irq_mask", data, 16'h0002);
    for (int i = 0; i < 2; i++)
    begin
      dir_q[i] = 16'h0001;
      bus_write(bank_addr(i[0], `GPR_DIRECTION_MODE), dir_q[i]);
    end
    @(posedge pclk26);
    pin_in <= '0;
    repeat (5) @(posedge pclk26);
    clear_status();
    @(posedge pclk26);
    pin_in <= 32'h0000_0001;                      // masked bank 0 edge
    repeat (6) @(posedge pclk26);
    @(negedge pclk26);
    check_pins("interrupt", interrupt, 32'h0000_0001);
    check_word("irq", 16'(irq), 16'h0000);
    bus_read(`GPR_IRQ_PENDING, data);
    check_word("rdata irq_pending", data, 16'h0001);
    check_word("irq", 16'(irq), 16'h0000);
    bus_read(bank_addr(1'b0, `GPR_INT_STATUS), data);
    check_word("rdata int_status", data, 16'h0001);
    @(posedge pclk26);
    pin_in <= 32'h0001_0001;                      // bank 1 edge
    for (int n = 0; n < 10 && !interrupt[`GPIO_WIDTH]; n++)
      @(negedge pclk26);
    assert (interrupt[`GPIO_WIDTH])
    else
    begin
      $display("bank 1 interrupt bit never set after a rising edge");
      $display("Simulation failed");
      $fatal(1, "missing interrupt");
    end
    check_word("irq", 16'(irq), 16'h0000);        // one cycle behind
    @(negedge pclk26);
    check_word("irq", 16'(irq), 16'h0001);
    bus_read(bank_addr(1'b1, `GPR_INT_STATUS), data);
    check_word("rdata int_status", data, 16'h0001);
    @(negedge pclk26);
    check_word("irq", 16'(irq), 16'h0000);
  endtask

  // ---------------------------------------------------------------------------
  // sequence
  // ---------------------------------------------------------------------------
  initial
  begin
    void'($urandom(32'h062e_06d8));
    read             = 1'b0;
    write            = 1'b0;
    addr             = '0;
    wdata            = '0;
    pin_in           = '0;
    tri_state_enable = '0;
    wait (n_reset26 === 1'b1);
    @(negedge pclk26);
    check_pins("pin_oe_n", pin_oe_n, '1);         // nothing driven after reset
    check_pins("pin_out", pin_out, '0);
    check_pins("interrupt", interrupt, '0);
    check_word("rdata", rdata, '0);
    check_word("irq", 16'(irq), 16'h0000);
    test_register_round_trip();
    test_pad_control();
    test_input_sync();
    test_edge_interrupt();
    test_irq_merge();
    $display("Simulation passed");
    $finish;
  end

endmodule : gpio_tb

`default_nettype wire

/* sources.f */
+incdir+include
logic/gpio_pkg.sv
logic/gpio_pin_bank.sv
logic/gpio_irq_merge.sv
logic/gpio_lite_top.sv
testbench/gpio_props.sv
testbench/gpio_clock_gen.sv
testbench/gpio_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the gpio testbench with Verilator and run it
# exit status is nonzero when the build fails or the run ends in $fatal

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module gpio_tb -f sources.f -o gpio_sim &&
  ./obj_dir/gpio_sim ||
  { echo "gpio simulation returned a failing status"; exit 1; }
